//--- hw/branchPredPkg.sv
`default_nettype none

package branchPredPkg;

    ////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////

    // Instruction address
    typedef logic [31:0] pcT;

    // 2-bit saturating counter whose upper bit is the prediction
    typedef logic [1:0] ctrlT;

    // Next-PC source reported by the resolver
    typedef logic [1:0] npcSelT;

    // Byte offset bits below the table index
    localparam int PcByteBits = 2;

    ////////////////////////////////////////
    // Counter encoding
    ////////////////////////////////////////

    localparam ctrlT ctrlStrongNot   = 2'b00;
    localparam ctrlT ctrlWeakNot     = 2'b01;
    localparam ctrlT ctrlWeakTaken   = 2'b10;
    localparam ctrlT ctrlStrongTaken = 2'b11;

    ////////////////////////////////////////
    // Next-PC source codes
    ////////////////////////////////////////

    localparam npcSelT npcSeq      = 2'b00;
    localparam npcSelT npcPred     = 2'b01;
    localparam npcSelT npcRedirect = 2'b10;

endpackage

`default_nettype wire

//--- hw/btbTable.sv
`default_nettype none

module btbTable
    import branchPredPkg::*;
#(
    parameter int IndexBits = 4
) (
    input  logic clk,
    input  logic rstN,

    // Fetch lookup
    input  pcT   fetchPc,
    output logic fetchHit,
    output ctrlT fetchCtrl,
    output pcT   fetchTarget,

    // Resolution lookup and write address
    input  pcT   resPc,
    output logic resHit,
    output ctrlT resCtrl,
    output pcT   resStoredTarget,

    // Update from the resolver
    input  logic writeEn,
    input  ctrlT writeCtrl,
    input  pcT   writeTarget
);

    localparam int Entries = 1 << IndexBits;
    localparam int TagBits = $bits(pcT) - IndexBits - PcByteBits;

    ////////////////////////////////////////
    // Address slicing
    ////////////////////////////////////////

    function automatic logic [IndexBits-1:0] idxOf(input pcT pc);
        return pc[IndexBits+PcByteBits-1:PcByteBits];
    endfunction

    function automatic logic [TagBits-1:0] tagOf(input pcT pc);
        return pc[$bits(pcT)-1:IndexBits+PcByteBits];
    endfunction

    ////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////

    logic               validQ  [Entries];
    logic [TagBits-1:0] tagQ    [Entries];
    pcT                 targetQ [Entries];
    ctrlT               ctrlQ   [Entries];

    logic [IndexBits-1:0] writeIdx;

    assign writeIdx = idxOf(resPc);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < Entries; i++)
            begin
                validQ[i] <= 1'b0;
            end
        end
        else if (writeEn)
        begin
            validQ[writeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (writeEn)
        begin
            tagQ[writeIdx]    <= tagOf(resPc);
            targetQ[writeIdx] <= writeTarget;
            ctrlQ[writeIdx]   <= writeCtrl;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Port 0 serves fetch and port 1 serves resolution
    pcT   lookupPc     [2];
    logic lookupHit    [2];
    ctrlT lookupCtrl   [2];
    pcT   lookupTarget [2];

    assign lookupPc[0] = fetchPc;
    assign lookupPc[1] = resPc;

    // Reads see the old contents during a write cycle
    always_comb
    begin
        for (int p = 0; p < 2; p++)
        begin
            lookupHit[p] = validQ[idxOf(lookupPc[p])]
                && (tagQ[idxOf(lookupPc[p])] == tagOf(lookupPc[p]));
            lookupCtrl[p]   = ctrlQ[idxOf(lookupPc[p])];
            lookupTarget[p] = targetQ[idxOf(lookupPc[p])];
        end
    end

    assign fetchHit        = lookupHit[0];
    assign fetchCtrl       = lookupCtrl[0];
    assign fetchTarget     = lookupTarget[0];
    assign resHit          = lookupHit[1];
    assign resCtrl         = lookupCtrl[1];
    assign resStoredTarget = lookupTarget[1];

    // The resolver must never leave the write strobe floating
    writeEnKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(writeEn))
    else $error("btbTable: writeEn is unknown");

endmodule

`default_nettype wire

//--- hw/branchResolve.sv
`default_nettype none

module branchResolve
    import branchPredPkg::*;
(
    // Resolution from execute
    input  logic   resValid,
    input  logic   resBranch,
    input  logic   resJump,
    input  logic   resTaken,
    input  pcT     resPc,
    input  pcT     resTarget,

    // Table contents for resPc
    input  logic   resHit,
    input  ctrlT   resCtrl,
    input  pcT     resStoredTarget,

    // Table update
    output logic   writeEn,
    output ctrlT   writeCtrl,
    output pcT     writeTarget,

    // Fetch redirect
    output logic   flush,
    output pcT     redirectPc,
    output npcSelT npcSel
);

    ////////////////////////////////////////
    // Saturating counter step
    ////////////////////////////////////////

    function automatic ctrlT stepCtrl(input ctrlT ctrl, input logic taken);
        ctrlT next;
        if (taken)
        begin
            next = (ctrl == ctrlStrongTaken) ? ctrl : ctrl + 2'd1;
        end
        else
        begin
            next = (ctrl == ctrlStrongNot) ? ctrl : ctrl - 2'd1;
        end
        return next;
    endfunction

    ////////////////////////////////////////
    // Outcome versus prediction
    ////////////////////////////////////////

    logic active;
    logic predTakenRes;
    logic actualTaken;
    logic targetMiss;

    assign active       = resValid && (resBranch || resJump);
    // Jumps are stored strongly taken so a hit alone predicts them
    assign predTakenRes = resJump ? resHit : (resHit && resCtrl[1]);
    assign actualTaken  = resJump || resTaken;
    assign targetMiss   = predTakenRes && actualTaken && (resStoredTarget != resTarget);

    assign flush      = active && ((predTakenRes != actualTaken) || targetMiss);
    assign redirectPc = actualTaken ? resTarget : resPc + 32'd4;

    ////////////////////////////////////////
    // Table update
    ////////////////////////////////////////

    // Not-taken branches that miss are never allocated
    assign writeEn     = active && (resJump || resHit || resTaken);
    assign writeTarget = resTarget;

    always_comb
    begin
        if (resJump)
        begin
            writeCtrl = ctrlStrongTaken;
        end
        else if (resHit)
        begin
            writeCtrl = stepCtrl(resCtrl, resTaken);
        end
        else
        begin
            writeCtrl = ctrlWeakTaken;
        end
    end

    // Source that fetch ends up on after this resolution
    always_comb
    begin
        if (flush)
        begin
            npcSel = npcRedirect;
        end
        else if (active && actualTaken)
        begin
            npcSel = npcPred;
        end
        else
        begin
            npcSel = npcSeq;
        end
    end

    // Execute only ever resolves one kind at a time
    always_comb
    begin
        if (resValid)
        begin
            assert (!(resBranch && resJump))
            else $error("branchResolve: branch and jump both set");
        end
    end

endmodule

`default_nettype wire

//--- hw/fetchPcGen.sv
`default_nettype none

module fetchPcGen
    import branchPredPkg::*;
#(
    parameter pcT ResetPc = 32'h0000_1000
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   fetchEn,

    // Fetch lookup result
    input  logic   fetchHit,
    input  ctrlT   fetchCtrl,
    input  pcT     fetchTarget,

    // Redirect from the resolver
    input  logic   flush,
    input  pcT     redirectPc,
    input  npcSelT npcSel,

    output pcT     fetchPc,
    output logic   predTaken
);

    pcT fetchPcQ;
    pcT nextPc;

    // Hit with upper counter bit set also covers jumps
    assign predTaken = fetchHit && fetchCtrl[1];

    ////////////////////////////////////////
    // Next fetch address
    ////////////////////////////////////////

    always_comb
    begin
        if (flush)
        begin
            // Redirect wins even while fetch is stalled
            nextPc = redirectPc;
        end
        else if (fetchEn)
        begin
            nextPc = predTaken ? fetchTarget : fetchPcQ + 32'd4;
        end
        else
        begin
            nextPc = fetchPcQ;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            fetchPcQ <= ResetPc;
        end
        else
        begin
            fetchPcQ <= nextPc;
        end
    end

    assign fetchPc = fetchPcQ;

    ////////////////////////////////////////
    // Cross-check against the resolver
    ////////////////////////////////////////

    flushMatchesSel: assert property (@(posedge clk) disable iff (!rstN)
        flush == (npcSel == npcRedirect))
    else $error("fetchPcGen: flush and npcSel disagree");

endmodule

`default_nettype wire

//--- hw/branchPredTop.sv
`default_nettype none

module branchPredTop
    import branchPredPkg::*;
#(
    parameter int IndexBits = 4,
    parameter pcT ResetPc   = 32'h0000_1000
) (
    input  logic clk,
    input  logic rstN,

    // Fetch side
    input  logic fetchEn,
    output pcT   fetchPc,
    output logic predTaken,

    // Execute side
    input  logic resValid,
    input  pcT   resPc,
    input  logic resBranch,
    input  logic resJump,
    input  logic resTaken,
    input  pcT   resTarget,
    output logic flush
);

    // Fetch lookup
    logic   fetchHit;
    ctrlT   fetchCtrl;
    pcT     fetchTarget;

    // Resolution lookup
    logic   resHit;
    ctrlT   resCtrl;
    pcT     resStoredTarget;

    // Update and redirect
    logic   writeEn;
    ctrlT   writeCtrl;
    pcT     writeTarget;
    pcT     redirectPc;
    npcSelT npcSel;

    btbTable #(
        .IndexBits(IndexBits)
    ) uTable (
        .clk            (clk),
        .rstN           (rstN),
        .fetchPc        (fetchPc),
        .fetchHit       (fetchHit),
        .fetchCtrl      (fetchCtrl),
        .fetchTarget    (fetchTarget),
        .resPc          (resPc),
        .resHit         (resHit),
        .resCtrl        (resCtrl),
        .resStoredTarget(resStoredTarget),
        .writeEn        (writeEn),
        .writeCtrl      (writeCtrl),
        .writeTarget    (writeTarget)
    );

    branchResolve uResolve (
        .resValid       (resValid),
        .resBranch      (resBranch),
        .resJump        (resJump),
        .resTaken       (resTaken),
        .resPc          (resPc),
        .resTarget      (resTarget),
        .resHit         (resHit),
        .resCtrl        (resCtrl),
        .resStoredTarget(resStoredTarget),
        .writeEn        (writeEn),
        .writeCtrl      (writeCtrl),
        .writeTarget    (writeTarget),
        .flush          (flush),
        .redirectPc     (redirectPc),
        .npcSel         (npcSel)
    );

    fetchPcGen #(
        .ResetPc(ResetPc)
    ) uPcGen (
        .clk        (clk),
        .rstN       (rstN),
        .fetchEn    (fetchEn),
        .fetchHit   (fetchHit),
        .fetchCtrl  (fetchCtrl),
        .fetchTarget(fetchTarget),
        .flush      (flush),
        .redirectPc (redirectPc),
        .npcSel     (npcSel),
        .fetchPc    (fetchPc),
        .predTaken  (predTaken)
    );

endmodule

`default_nettype wire

//--- verif/branchPredTb.sv
`default_nettype none

module branchPredTb
    import branchPredPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IndexBits = 4;
    localparam pcT ResetPc   = 32'h0000_1000;
    localparam int Entries   = 1 << IndexBits;

    logic clk;
    logic rstN;
    logic fetchEn;
    logic resValid;
    logic resBranch;
    logic resJump;
    logic resTaken;
    pcT   resPc;
    pcT   resTarget;
    pcT   fetchPc;
    logic predTaken;
    logic flush;

    logic [31:0] lfsrState = 32'h0ba7d487;

    branchPredTop #(
        .IndexBits(IndexBits),
        .ResetPc  (ResetPc)
    ) dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped on the first error");
    endtask

    // Galois form of x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic drawBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    ////////////////////////////////////////
    // Reference table model
    ////////////////////////////////////////

    function automatic logic [IndexBits-1:0] entryOf(input pcT pc);
        return pc[IndexBits+1:2];
    endfunction

    function automatic pcT tagBitsOf(input pcT pc);
        return pc >> (IndexBits + 2);
    endfunction

    logic                 mValid  [Entries];
    pcT                   mTag    [Entries];
    pcT                   mTarget [Entries];
    ctrlT                 mCtrl   [Entries];
    pcT                   expPc;
    pcT                   expRedirect;
    pcT                   expNextPc;
    logic [IndexBits-1:0] fIdx;
    logic [IndexBits-1:0] rIdx;
    logic                 rHit;
    logic                 expPredTaken;
    logic                 expFlush;
    logic                 expWrite;
    ctrlT                 expCtrl;

    always_comb
    begin
        logic active;
        logic predT;
        logic actT;
        int   level;
        fIdx         = entryOf(expPc);
        expPredTaken = mValid[fIdx] && (mTag[fIdx] == tagBitsOf(expPc)) && mCtrl[fIdx][1];
        rIdx         = entryOf(resPc);
        rHit         = mValid[rIdx] && (mTag[rIdx] == tagBitsOf(resPc));
        active       = resValid && (resBranch || resJump);
        predT        = rHit && (resJump || mCtrl[rIdx][1]);
        actT         = resJump || resTaken;
        expFlush     = active && ((predT != actT)
            || (predT && actT && (mTarget[rIdx] != resTarget)));
        expRedirect  = actT ? resTarget : resPc + 32'd4;
        expWrite     = active && (resJump || rHit || resTaken);
        // Counter moves one step toward the outcome and sticks at the ends
        level = int'(mCtrl[rIdx]) + (resTaken ? 1 : -1);
        if (level > 3)
        begin
            level = 3;
        end
        if (level < 0)
        begin
            level = 0;
        end
        if (resJump)
        begin
            expCtrl = ctrlStrongTaken;
        end
        else if (!rHit)
        begin
            expCtrl = ctrlWeakTaken;
        end
        else
        begin
            expCtrl = ctrlT'(level);
        end
        if (expFlush)
        begin
            expNextPc = expRedirect;
        end
        else if (fetchEn)
        begin
            expNextPc = expPredTaken ? mTarget[fIdx] : expPc + 32'd4;
        end
        else
        begin
            expNextPc = expPc;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < Entries; i++)
            begin
                mValid[i]  <= 1'b0;
                mTag[i]    <= '0;
                mTarget[i] <= '0;
                mCtrl[i]   <= ctrlStrongNot;
            end
            expPc <= ResetPc;
        end
        else
        begin
            if (expWrite)
            begin
                mValid[rIdx]  <= 1'b1;
                mTag[rIdx]    <= tagBitsOf(resPc);
                mTarget[rIdx] <= resTarget;
                mCtrl[rIdx]   <= expCtrl;
            end
            expPc <= expNextPc;
        end
    end

    ////////////////////////////////////////
    // Checks against the model
    ////////////////////////////////////////

    pcCheck: assert property (@(posedge clk) disable iff (!rstN) fetchPc == expPc)
    else failRun($sformatf("[FAIL] %0t ns: fetchPc %h, expected %h",
        $time, $sampled(fetchPc), $sampled(expPc)));

    predCheck: assert property (@(posedge clk) disable iff (!rstN) predTaken == expPredTaken)
    else failRun($sformatf("[FAIL] %0t ns: predTaken %b at %h, expected %b",
        $time, $sampled(predTaken), $sampled(fetchPc), $sampled(expPredTaken)));

    flushCheck: assert property (@(posedge clk) disable iff (!rstN) flush == expFlush)
    else failRun($sformatf("[FAIL] %0t ns: flush %b for resPc %h, expected %b",
        $time, $sampled(flush), $sampled(resPc), $sampled(expFlush)));

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic idleRes();
        resValid  = 1'b0;
        resBranch = 1'b0;
        resJump   = 1'b0;
        resTaken  = 1'b0;
    endtask

    task automatic resolve(input logic branch, input logic jump, input logic taken,
                           input pcT pc, input pcT target);
        resValid  = 1'b1;
        resBranch = branch;
        resJump   = jump;
        resTaken  = taken;
        resPc     = pc;
        resTarget = target;
        tick();
    endtask

    task automatic waitFetchAt(input pcT pc, input int limit);
        int count;
        count = 0;
        while ((fetchPc != pc) && (count < limit))
        begin
            tick();
            count++;
        end
        if (fetchPc != pc)
        begin
            failRun($sformatf("Timeout while waiting for fetch to reach %h", pc));
        end
    endtask

    initial
    begin
        #200_000;
        failRun("Watchdog expired before the run finished");
    end

    initial
    begin
        logic [31:0] r;
        rstN      = 1'b0;
        fetchEn   = 1'b0;
        resPc     = ResetPc;
        resTarget = ResetPc;
        idleRes();
        repeat (5) @(posedge clk);
        #5;
        rstN = 1'b1;

        // Sequential fetch with a stall
        fetchEn = 1'b1;
        repeat (4) tick();
        fetchEn = 1'b0;
        repeat (2) tick();

        // Loop-closing jump that misses and is then predicted at fetch
        resolve(1'b0, 1'b1, 1'b1, 32'h1020, 32'h1004);
        idleRes();
        fetchEn = 1'b1;
        waitFetchAt(32'h1020, 40);
        tick();

        // Branch trained up, down to strongly not taken and back up
        fetchEn = 1'b0;
        repeat (3) resolve(1'b1, 1'b0, 1'b1, 32'h1010, 32'h1018);
        repeat (4) resolve(1'b1, 1'b0, 1'b0, 32'h1010, 32'h1018);
        idleRes();
        fetchEn = 1'b1;
        waitFetchAt(32'h1010, 40);
        tick();
        fetchEn = 1'b0;
        repeat (2) resolve(1'b1, 1'b0, 1'b1, 32'h1010, 32'h1018);
        idleRes();
        fetchEn = 1'b1;
        waitFetchAt(32'h1010, 40);
        tick();

        // New target on a hit
        fetchEn = 1'b0;
        repeat (2) resolve(1'b0, 1'b1, 1'b1, 32'h1020, 32'h1008);
        idleRes();
        fetchEn = 1'b1;
        waitFetchAt(32'h1020, 40);
        tick();

        // Not-taken miss and a non-branch leave the table alone
        fetchEn = 1'b0;
        resolve(1'b1, 1'b0, 1'b0, 32'h100C, 32'h1200);
        resolve(1'b0, 1'b0, 1'b1, 32'h1014, 32'h1300);
        idleRes();
        fetchEn = 1'b1;
        waitFetchAt(32'h100C, 40);
        tick();

        // Random mix over a pool of PCs that alias in the table
        for (int n = 0; n < 600; n++)
        begin
            drawBits(2, r);
            resValid = (r[1:0] != 2'd0);
            drawBits(2, r);
            resBranch = (r[1] == 1'b0);
            resJump   = (r[1:0] == 2'd2);
            drawBits(1, r);
            resTaken = r[0];
            drawBits(5, r);
            resPc = 32'h1000 + {25'd0, r[4:0], 2'b00};
            drawBits(5, r);
            resTarget = 32'h1000 + {25'd0, r[4:0], 2'b00};
            drawBits(2, r);
            fetchEn = (r[1:0] != 2'd0);
            tick();
        end
        idleRes();
        repeat (3) tick();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/branchPredPkg.sv
hw/btbTable.sv
hw/branchResolve.sv
hw/fetchPcGen.sv
hw/branchPredTop.sv
verif/branchPredTb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log
verilator --binary --timing --assert --timescale 1ns/100ps -f list.f \
    --top-module branchPredTb -o simv > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -q "^=== PASS ===$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
